//--- verilog/ip_eth_tx_config.svh
// widths and fixed IPv4 constants for the frame transmitter
// IHL is fixed at 5, so IP options are not supported
`ifndef IP_ETH_TX_CONFIG_SVH
`define IP_ETH_TX_CONFIG_SVH

`define MAC_W        48
`define IPV4_W       32

`define IP_VERSION   4
`define IP_IHL       5

// header length follows from IHL 5
`define IP_HDR_BYTES 20
`define HDR_IDX_W    5

`endif

//--- verilog/ip_eth_pkg.sv
// shared types of the IPv4-over-Ethernet transmitter
// struct widths come from the config header
`include "ip_eth_tx_config.svh"

package ip_eth_pkg;

    // ethernet header, fields in wire order
    typedef struct packed {
        logic [`MAC_W-1:0] dst_mac;
        logic [`MAC_W-1:0] src_mac;
        logic [15:0]       eth_type;
    } eth_hdr_t;

    // ipv4 header fields supplied by the user
    // version, IHL and checksum are generated internally
    typedef struct packed {
        logic [5:0]         dscp;
        logic [1:0]         ecn;
        logic [15:0]        length;
        logic [15:0]        identification;
        logic [2:0]         flags;
        logic [12:0]        frag_offset;
        logic [7:0]         ttl;
        logic [7:0]         protocol;
        logic [`IPV4_W-1:0] src_ip;
        logic [`IPV4_W-1:0] dst_ip;
    } ip_hdr_t;

    // one byte per beat
    typedef struct packed {
        logic [7:0] data;
        logic       last;
        logic       user;
    } axis_beat_t;

    typedef enum logic [1:0] {
        tx_idle,
        tx_header,
        tx_payload
    } tx_state_e;

endpackage

//--- verilog/ip_hdr_checksum.sv
// combinational IPv4 header checksum, one's complement sum of ten words
// ip_hdr must stay stable while the header bytes are sent
`timescale 1ns/1ps
`include "ip_eth_tx_config.svh"

module ip_hdr_checksum (
    input  ip_eth_pkg::ip_hdr_t ip_hdr,
    output logic [15:0]         checksum
);

    logic [19:0] sum;
    logic [16:0] fold;
    logic [15:0] folded;

    // checksum word itself counts as zero and is left out
    always_comb begin
        sum = 20'({4'(`IP_VERSION), 4'(`IP_IHL), ip_hdr.dscp, ip_hdr.ecn})
            + 20'(ip_hdr.length)
            + 20'(ip_hdr.identification)
            + 20'({ip_hdr.flags, ip_hdr.frag_offset})
            + 20'({ip_hdr.ttl, ip_hdr.protocol})
            + 20'(ip_hdr.src_ip[31:16])
            + 20'(ip_hdr.src_ip[15:0])
            + 20'(ip_hdr.dst_ip[31:16])
            + 20'(ip_hdr.dst_ip[15:0]);
    end

    // end-around carry, two folds are enough for nine words
    always_comb begin
        fold   = 17'(sum[15:0]) + 17'(sum[19:16]);
        folded = fold[15:0] + 16'(fold[16]);
    end

    assign checksum = ~folded;

endmodule

//--- verilog/ip_hdr_serializer.sv
// picks one IPv4 header byte by index, network byte order
// indices above 19 return zero
`timescale 1ns/1ps
`include "ip_eth_tx_config.svh"

module ip_hdr_serializer (
    input  ip_eth_pkg::ip_hdr_t    ip_hdr,
    input  logic [15:0]            checksum,
    input  logic [`HDR_IDX_W-1:0]  hdr_idx,
    output logic [7:0]             hdr_byte
);

    always_comb begin
        case (int'(hdr_idx))
            0:  hdr_byte = {4'(`IP_VERSION), 4'(`IP_IHL)};
            1:  hdr_byte = {ip_hdr.dscp, ip_hdr.ecn};
            2:  hdr_byte = ip_hdr.length[15:8];
            3:  hdr_byte = ip_hdr.length[7:0];
            4:  hdr_byte = ip_hdr.identification[15:8];
            5:  hdr_byte = ip_hdr.identification[7:0];
            // flags share a byte with the upper offset bits
            6:  hdr_byte = {ip_hdr.flags, ip_hdr.frag_offset[12:8]};
            7:  hdr_byte = ip_hdr.frag_offset[7:0];
            8:  hdr_byte = ip_hdr.ttl;
            9:  hdr_byte = ip_hdr.protocol;
            10: hdr_byte = checksum[15:8];
            11: hdr_byte = checksum[7:0];
            12: hdr_byte = ip_hdr.src_ip[31:24];
            13: hdr_byte = ip_hdr.src_ip[23:16];
            14: hdr_byte = ip_hdr.src_ip[15:8];
            15: hdr_byte = ip_hdr.src_ip[7:0];
            16: hdr_byte = ip_hdr.dst_ip[31:24];
            17: hdr_byte = ip_hdr.dst_ip[23:16];
            18: hdr_byte = ip_hdr.dst_ip[15:8];
            19: hdr_byte = ip_hdr.dst_ip[7:0];
            default: hdr_byte = 8'h00;
        endcase
    end

endmodule

//--- verilog/ip_tx_ctrl.sv
// frame FSM: header capture, header byte stepping, payload length check
// payloads longer than declared pass through whole and are not flagged
`timescale 1ns/1ps
`include "ip_eth_tx_config.svh"

module ip_tx_ctrl (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   hdr_valid,
    output logic                   hdr_ready,
    input  ip_eth_pkg::eth_hdr_t   eth_hdr_in,
    input  ip_eth_pkg::ip_hdr_t    ip_hdr_in,
    input  logic                   pl_valid,
    output logic                   pl_ready,
    input  ip_eth_pkg::axis_beat_t pl_in,
    output logic                   eth_hdr_valid,
    input  logic                   eth_hdr_ready,
    output ip_eth_pkg::eth_hdr_t   eth_hdr_out,
    output logic                   busy,
    output logic                   error_early_end,
    output ip_eth_pkg::ip_hdr_t    ip_hdr,
    output logic [`HDR_IDX_W-1:0]  hdr_idx,
    input  logic [7:0]             hdr_byte,
    output logic                   beat_valid,
    output ip_eth_pkg::axis_beat_t beat,
    input  logic                   in_ready
);

    localparam int unsigned idx_w = `HDR_IDX_W;
    localparam logic [idx_w-1:0] last_hdr_idx = idx_w'(`IP_HDR_BYTES - 1);

    ip_eth_pkg::tx_state_e state_q;
    ip_eth_pkg::tx_state_e state_next;

    logic        hdr_xfer;
    logic        pl_xfer;
    logic        early_end;
    logic        eth_hdr_valid_next;
    // payload bytes still expected, saturates at zero
    logic [15:0] pl_cnt_q;

    assign hdr_xfer = hdr_valid && hdr_ready;
    assign pl_ready = (state_q == ip_eth_pkg::tx_payload) && in_ready;
    assign pl_xfer  = pl_valid && pl_ready;

    // last beat while more than one byte was still owed
    assign early_end = pl_xfer && pl_in.last && (pl_cnt_q > 16'd1);

    assign eth_hdr_valid_next = hdr_xfer || (eth_hdr_valid && !eth_hdr_ready);

    always_comb begin
        state_next = state_q;
        beat_valid = 1'b0;
        beat       = '{data: hdr_byte, last: 1'b0, user: 1'b0};
        case (state_q)
            ip_eth_pkg::tx_idle: begin
                if (hdr_xfer) begin
                    state_next = ip_eth_pkg::tx_header;
                end
            end
            ip_eth_pkg::tx_header: begin
                // one header byte per cycle the skid buffer can take it
                beat_valid = in_ready;
                if (in_ready && hdr_idx == last_hdr_idx) begin
                    state_next = ip_eth_pkg::tx_payload;
                end
            end
            ip_eth_pkg::tx_payload: begin
                beat_valid = pl_xfer;
                beat = '{data: pl_in.data, last: pl_in.last, user: pl_in.user || early_end};
                if (pl_xfer && pl_in.last) begin
                    state_next = ip_eth_pkg::tx_idle;
                end
            end
            default: begin
                state_next = ip_eth_pkg::tx_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q         <= ip_eth_pkg::tx_idle;
            hdr_ready       <= 1'b0;
            eth_hdr_valid   <= 1'b0;
            busy            <= 1'b0;
            error_early_end <= 1'b0;
            hdr_idx         <= '0;
            pl_cnt_q        <= '0;
        end else begin
            state_q         <= state_next;
            // no new header until the previous eth header is taken
            hdr_ready       <= (state_next == ip_eth_pkg::tx_idle) && !eth_hdr_valid_next;
            eth_hdr_valid   <= eth_hdr_valid_next;
            busy            <= state_next != ip_eth_pkg::tx_idle;
            error_early_end <= early_end;

            if (hdr_xfer) begin
                hdr_idx <= '0;
            end else if (state_q == ip_eth_pkg::tx_header && in_ready) begin
                hdr_idx <= hdr_idx + idx_w'(1);
            end

            if (hdr_xfer) begin
                pl_cnt_q <= ip_hdr_in.length - 16'(`IP_HDR_BYTES);
            end else if (pl_xfer && pl_cnt_q != 16'd0) begin
                pl_cnt_q <= pl_cnt_q - 16'd1;
            end
        end
    end

    // header fields, held for the whole frame
    always_ff @(posedge clk) begin
        if (hdr_xfer) begin
            eth_hdr_out <= eth_hdr_in;
            ip_hdr      <= ip_hdr_in;
        end
    end

    a_eth_hdr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        eth_hdr_valid && !eth_hdr_ready |=> eth_hdr_valid && $stable(eth_hdr_out))
        else $error("eth header changed or dropped before eth_hdr_ready");

    // skid buffer has room for a beat only when in_ready is high
    a_beat_needs_ready: assert property (@(posedge clk) disable iff (!rst_n)
        beat_valid |-> in_ready)
        else $error("beat offered while in_ready low");

endmodule

//--- verilog/axis_skid_buffer.sv
// two-entry output register for the byte stream, full rate under back-pressure
// sender must offer a beat only while in_ready is high
`timescale 1ns/1ps

module axis_skid_buffer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   beat_valid,
    input  ip_eth_pkg::axis_beat_t beat,
    output logic                   in_ready,
    output logic                   out_valid,
    input  logic                   out_ready,
    output ip_eth_pkg::axis_beat_t out
);

    ip_eth_pkg::axis_beat_t temp_q;
    logic                   temp_valid_q;
    logic                   out_valid_next;
    logic                   temp_valid_next;
    logic                   load_out;
    logic                   load_temp;
    logic                   temp_to_out;

    always_comb begin
        out_valid_next  = out_valid;
        temp_valid_next = temp_valid_q;
        load_out        = 1'b0;
        load_temp       = 1'b0;
        temp_to_out     = 1'b0;
        if (in_ready) begin
            if (out_ready || !out_valid) begin
                out_valid_next = beat_valid;
                load_out       = 1'b1;
            end else begin
                // output stalled, park the beat
                temp_valid_next = beat_valid;
                load_temp       = 1'b1;
            end
        end else if (out_ready) begin
            out_valid_next  = temp_valid_q;
            temp_valid_next = 1'b0;
            temp_to_out     = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_ready     <= 1'b0;
            out_valid    <= 1'b0;
            temp_valid_q <= 1'b0;
        end else begin
            in_ready     <= out_ready || (!temp_valid_q && !out_valid);
            out_valid    <= out_valid_next;
            temp_valid_q <= temp_valid_next;
        end
    end

    always_ff @(posedge clk) begin
        if (load_out) begin
            out <= beat;
        end else if (temp_to_out) begin
            out <= temp_q;
        end
        if (load_temp) begin
            temp_q <= beat;
        end
    end

    a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out))
        else $error("output beat changed while stalled");

endmodule

//--- verilog/ip_eth_tx.sv
// IPv4 over Ethernet transmitter, header fields in parallel, one byte per beat
// emits the 20-byte IPv4 header then the payload, no IP options
`timescale 1ns/1ps
`include "ip_eth_tx_config.svh"

module ip_eth_tx (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   hdr_valid,
    output logic                   hdr_ready,
    input  ip_eth_pkg::eth_hdr_t   eth_hdr_in,
    input  ip_eth_pkg::ip_hdr_t    ip_hdr_in,
    input  logic                   pl_valid,
    output logic                   pl_ready,
    input  ip_eth_pkg::axis_beat_t pl_in,
    output logic                   eth_hdr_valid,
    input  logic                   eth_hdr_ready,
    output ip_eth_pkg::eth_hdr_t   eth_hdr_out,
    output logic                   out_valid,
    input  logic                   out_ready,
    output ip_eth_pkg::axis_beat_t out,
    output logic                   busy,
    output logic                   error_early_end
);

    ip_eth_pkg::ip_hdr_t    ip_hdr;
    ip_eth_pkg::axis_beat_t beat;
    logic [15:0]            checksum;
    logic [`HDR_IDX_W-1:0]  hdr_idx;
    logic [7:0]             hdr_byte;
    logic                   beat_valid;
    logic                   in_ready;

    ip_tx_ctrl i_ip_tx_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .hdr_valid       (hdr_valid),
        .hdr_ready       (hdr_ready),
        .eth_hdr_in      (eth_hdr_in),
        .ip_hdr_in       (ip_hdr_in),
        .pl_valid        (pl_valid),
        .pl_ready        (pl_ready),
        .pl_in           (pl_in),
        .eth_hdr_valid   (eth_hdr_valid),
        .eth_hdr_ready   (eth_hdr_ready),
        .eth_hdr_out     (eth_hdr_out),
        .busy            (busy),
        .error_early_end (error_early_end),
        .ip_hdr          (ip_hdr),
        .hdr_idx         (hdr_idx),
        .hdr_byte        (hdr_byte),
        .beat_valid      (beat_valid),
        .beat            (beat),
        .in_ready        (in_ready)
    );

    ip_hdr_checksum i_ip_hdr_checksum (
        .ip_hdr   (ip_hdr),
        .checksum (checksum)
    );

    ip_hdr_serializer i_ip_hdr_serializer (
        .ip_hdr   (ip_hdr),
        .checksum (checksum),
        .hdr_idx  (hdr_idx),
        .hdr_byte (hdr_byte)
    );

    axis_skid_buffer i_axis_skid_buffer (
        .clk        (clk),
        .rst_n      (rst_n),
        .beat_valid (beat_valid),
        .beat       (beat),
        .in_ready   (in_ready),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out        (out)
    );

endmodule

//--- sim/tb_ip_eth_model.svh
// reference model of the transmitter byte stream, plus the xorshift source
// assumes payload user bits low and a declared length of at least 20
`ifndef TB_IP_ETH_MODEL_SVH
`define TB_IP_ETH_MODEL_SVH

typedef logic [7:0] byte_q_t[$];
typedef ip_eth_pkg::axis_beat_t beat_q_t[$];

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
endfunction

// header in wire order, checksum field still zero
function automatic logic [159:0] ip_header_raw(input ip_eth_pkg::ip_hdr_t h);
    return {4'(`IP_VERSION), 4'(`IP_IHL), h.dscp, h.ecn, h.length, h.identification,
            h.flags, h.frag_offset, h.ttl, h.protocol, 16'h0000, h.src_ip, h.dst_ip};
endfunction

// one's complement sum of the ten words, inverted
function automatic logic [15:0] ref_checksum(input logic [159:0] raw);
    logic [31:0] acc;
    acc = 32'd0;
    for (int i = 0; i < 10; i++) begin
        acc = acc + 32'(raw[159 - 16 * i -: 16]);
    end
    while (acc[31:16] != 16'd0) begin
        acc = 32'(acc[15:0]) + 32'(acc[31:16]);
    end
    return ~acc[15:0];
endfunction

function automatic beat_q_t expected_frame(input ip_eth_pkg::ip_hdr_t h, input byte_q_t pl);
    beat_q_t                q;
    ip_eth_pkg::axis_beat_t b;
    logic [159:0]           raw;
    int                     owed;
    raw = ip_header_raw(h);
    raw[79:64] = ref_checksum(raw);
    for (int i = 0; i < 20; i++) begin
        b.data = raw[159 - 8 * i -: 8];
        b.last = 1'b0;
        b.user = 1'b0;
        q.push_back(b);
    end
    // a short payload gets user on its final byte
    owed = int'(h.length) - 20;
    for (int i = 0; i < pl.size(); i++) begin
        b.data = pl[i];
        b.last = i == pl.size() - 1;
        b.user = (i == pl.size() - 1) && (pl.size() < owed);
        q.push_back(b);
    end
    return q;
endfunction

`endif

//--- sim/tb_ip_eth_tx.sv
// testbench for ip_eth_tx that compares the output beat by beat with the reference model
// payload user bits are driven low and declared lengths are never below 20
`timescale 1ns/1ps
`include "ip_eth_tx_config.svh"

module tb_ip_eth_tx;

    `include "tb_ip_eth_model.svh"

    localparam logic [31:0] seed = 32'h4a08_cf2d;
    localparam int unsigned timeout_cycles = 2000;

    logic                   clk = 1'b0;
    logic                   rst_n = 1'b0;
    logic                   hdr_valid = 1'b0;
    logic                   hdr_ready;
    ip_eth_pkg::eth_hdr_t   eth_hdr_in = '0;
    ip_eth_pkg::ip_hdr_t    ip_hdr_in = '0;
    logic                   pl_valid = 1'b0;
    logic                   pl_ready;
    ip_eth_pkg::axis_beat_t pl_in = '0;
    logic                   eth_hdr_valid;
    logic                   eth_hdr_ready = 1'b0;
    ip_eth_pkg::eth_hdr_t   eth_hdr_out;
    logic                   out_valid;
    logic                   out_ready = 1'b0;
    ip_eth_pkg::axis_beat_t out;
    logic                   busy;
    logic                   error_early_end;

    logic [31:0]            stim_rng = seed;
    logic [31:0]            ready_rng = seed ^ 32'h9e37_79b9;
    logic                   out_ready_random = 1'b0;
    logic                   eth_hold = 1'b0;
    beat_q_t                exp_q;
    ip_eth_pkg::eth_hdr_t   eth_exp_q[$];
    int unsigned            early_count = 0;
    int unsigned            early_expected = 0;

    ip_eth_tx i_ip_eth_tx (.*);

    always #5 clk = ~clk;

    // sinks for the byte stream and the eth header
    always @(posedge clk) begin
        #1;
        ready_rng = xorshift32(ready_rng);
        if (out_ready_random) begin
            out_ready     = ready_rng[7:6] != 2'b00;
            eth_hdr_ready = !eth_hold && (ready_rng[3] || ready_rng[4]);
        end else begin
            out_ready     = 1'b1;
            eth_hdr_ready = !eth_hold;
        end
    end

    task automatic fail_stop(input string reason);
        $display("CHECKS FAILED");
        $fatal(1, "%s", reason);
    endtask

    task automatic check_flag(input string name, input logic got, input logic expected);
        assert (got === expected) else begin
            $display("** Error: %s = %h, expected %h", name, got, expected);
            fail_stop("signal value mismatch");
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] got,
                              input logic [7:0] expected);
        assert (got === expected) else begin
            $display("** Error: %s = %h, expected %h", name, got, expected);
            fail_stop("byte value mismatch");
        end
    endtask

    task automatic check_eth(input ip_eth_pkg::eth_hdr_t got,
                             input ip_eth_pkg::eth_hdr_t expected);
        assert (got === expected) else begin
            $display("** Error: eth_hdr_out = %h, expected %h", got, expected);
            fail_stop("ethernet header mismatch");
        end
    endtask

    // accepted output beats and eth headers against the reference queues
    always @(posedge clk) begin : compare_out
        ip_eth_pkg::axis_beat_t want;
        ip_eth_pkg::eth_hdr_t   want_eth;
        if (rst_n && out_valid && out_ready) begin
            assert (exp_q.size() != 0) else fail_stop("output beat with no expected byte left");
            want = exp_q.pop_front();
            check_byte("out.data", out.data, want.data);
            check_flag("out.last", out.last, want.last);
            check_flag("out.user", out.user, want.user);
        end
        if (rst_n && eth_hdr_valid && eth_hdr_ready) begin
            assert (eth_exp_q.size() != 0) else fail_stop("eth header with none expected");
            want_eth = eth_exp_q.pop_front();
            check_eth(eth_hdr_out, want_eth);
        end
        if (rst_n && error_early_end) begin
            early_count++;
        end
    end

    task automatic draw(output logic [31:0] value);
        stim_rng = xorshift32(stim_rng);
        value    = stim_rng;
    endtask

    // hdr_ready is a register, so the level seen here holds until the next edge
    task automatic send_header(input ip_eth_pkg::eth_hdr_t eth, input ip_eth_pkg::ip_hdr_t ip);
        int unsigned waited;
        hdr_valid  = 1'b1;
        eth_hdr_in = eth;
        ip_hdr_in  = ip;
        waited     = 0;
        while (!hdr_ready) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > timeout_cycles) begin
                fail_stop("header was not accepted before the timeout");
            end
        end
        @(posedge clk);
        #1;
        hdr_valid = 1'b0;
        // first cycle after acceptance
        check_flag("hdr_ready", hdr_ready, 1'b0);
        check_flag("eth_hdr_valid", eth_hdr_valid, 1'b1);
        check_flag("busy", busy, 1'b1);
    endtask

    task automatic send_payload(input byte_q_t pl, input logic gaps);
        logic [31:0] r;
        int unsigned waited;
        foreach (pl[i]) begin
            if (gaps) begin
                draw(r);
                pl_valid = 1'b0;
                repeat (r[1:0]) begin
                    @(posedge clk);
                    #1;
                end
            end
            pl_valid = 1'b1;
            pl_in    = '{data: pl[i], last: i == pl.size() - 1, user: 1'b0};
            waited   = 0;
            while (!pl_ready) begin
                @(posedge clk);
                #1;
                waited++;
                if (waited > timeout_cycles) begin
                    fail_stop("payload beat was not accepted before the timeout");
                end
            end
            // busy stays high through the cycle of the last transfer
            check_flag("busy", busy, 1'b1);
            @(posedge clk);
            #1;
        end
        pl_valid = 1'b0;
    endtask

    task automatic run_frame(input int unsigned pl_len, input int unsigned declared,
                             input logic gaps);
        logic [31:0]          r [9];
        logic [31:0]          x;
        ip_eth_pkg::eth_hdr_t eth;
        ip_eth_pkg::ip_hdr_t  ip;
        byte_q_t              pl;
        beat_q_t              frame;
        for (int i = 0; i < 9; i++) begin
            draw(r[i]);
        end
        eth = {r[0], r[1], r[2], r[3][15:0]};
        ip = {r[4], r[5], r[6], r[7], r[8][7:0]};
        ip.length = 16'(declared);
        repeat (pl_len) begin
            draw(x);
            pl.push_back(x[7:0]);
        end
        frame = expected_frame(ip, pl);
        foreach (frame[i]) begin
            exp_q.push_back(frame[i]);
        end
        eth_exp_q.push_back(eth);
        if (pl_len < declared - 32'd20) begin
            early_expected++;
        end
        send_header(eth, ip);
        send_payload(pl, gaps);
    endtask

    task automatic wait_drain();
        int unsigned waited;
        waited = 0;
        while (exp_q.size() != 0 || busy || eth_hdr_valid) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > timeout_cycles) begin
                fail_stop("output stream did not drain before the timeout");
            end
        end
        assert (early_count == early_expected) else begin
            $display("** Error: error_early_end count = %h, expected %h",
                     early_count, early_expected);
            fail_stop("wrong number of early end pulses");
        end
    endtask

    initial begin
        logic [31:0] r;
        int unsigned pl_len;
        int unsigned declared;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // quiet idle state
        repeat (4) @(posedge clk);
        #1;
        repeat (8) begin
            check_flag("hdr_ready", hdr_ready, 1'b1);
            check_flag("out_valid", out_valid, 1'b0);
            check_flag("eth_hdr_valid", eth_hdr_valid, 1'b0);
            check_flag("busy", busy, 1'b0);
            @(posedge clk);
            #1;
        end
        // exact length at full output rate
        run_frame(26, 46, 1'b0);
        wait_drain();
        // eth header sink stalls and no second header may enter
        eth_hold = 1'b1;
        run_frame(8, 28, 1'b0);
        draw(r);
        repeat (32'(r[3:0]) + 32'd4) begin
            @(posedge clk);
            #1;
            check_flag("eth_hdr_valid", eth_hdr_valid, 1'b1);
            check_flag("hdr_ready", hdr_ready, 1'b0);
            check_eth(eth_hdr_out, eth_exp_q[0]);
        end
        eth_hold = 1'b0;
        wait_drain();
        // payload ends well before the declared length
        run_frame(10, 60, 1'b0);
        wait_drain();
        // back-to-back frames with gaps and back-pressure
        out_ready_random = 1'b1;
        for (int n = 0; n < 8; n++) begin
            draw(r);
            pl_len = 32'(r[5:0]) + 32'd1;
            case (r[9:8])
                2'd1: declared = pl_len + 32'd21 + 32'(r[11:10]);
                2'd2: declared = pl_len / 32'd2 + 32'd20;
                default: declared = pl_len + 32'd20;
            endcase
            run_frame(pl_len, declared, 1'b1);
        end
        wait_drain();
        if (exp_q.size() == 0 && eth_exp_q.size() == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            fail_stop("expected output left over at the end of the run");
        end
    end

endmodule

//--- build.f
+incdir+verilog
+incdir+sim
verilog/ip_eth_pkg.sv
verilog/ip_hdr_checksum.sv
verilog/ip_hdr_serializer.sv
verilog/ip_tx_ctrl.sv
verilog/axis_skid_buffer.sv
verilog/ip_eth_tx.sv
sim/tb_ip_eth_tx.sv

//--- run.sh
#!/bin/sh
# builds the testbench with Verilator and runs it, exit status is the result
verilator --binary --timing --assert -f build.f --top-module tb_ip_eth_tx -o tb_ip_eth_tx \
    && ./obj_dir/tb_ip_eth_tx \
    || exit 1
